/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_mips_cpu
FILELIST = all.f

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Test passed"

clean:
	rm -rf obj_dir

/* all.f */
+incdir+.
mips_pkg.sv
mips_control.sv
mips_pc_unit.sv
mips_regfile.sv
mips_alu.sv
mips_cpu.sv
tb_mips_mem.sv
tb_mips_cpu.sv

/* mips_alu.sv */
`timescale 1ns/1ns
`include "mips_defines.svh"

module mips_alu (
	input  mips_pkg::alu_op_t     alu_op,
	input  logic                  alu_src,
	input  logic [`MIPS_XLEN-1:0] rs_value,
	input  logic [`MIPS_XLEN-1:0] rt_value,
	input  logic [15:0]           imm16,
	output logic [`MIPS_XLEN-1:0] alu_result,
	output logic                  zero
);
	import mips_pkg::*;

	logic [`MIPS_XLEN-1:0] sign_imm;  // Immediate widened to a word
	logic [`MIPS_XLEN-1:0] operand_b;
	logic                  less_than; // Signed rs < B

	assign sign_imm = {{(`MIPS_XLEN-16){imm16[15]}}, imm16};

	// Immediate for lw, sw and addi
	assign operand_b = alu_src ? sign_imm : rt_value;

	assign less_than = $signed(rs_value) < $signed(operand_b);

	always_comb begin
		case (alu_op)
			ALU_AND: alu_result = rs_value & operand_b;
			ALU_OR:  alu_result = rs_value | operand_b;
			ALU_ADD: alu_result = rs_value + operand_b; // Also address calc
			ALU_SUB: alu_result = rs_value - operand_b; // beq compare
			ALU_SLT: alu_result = {{(`MIPS_XLEN-1){1'b0}}, less_than};
			default: alu_result = rs_value + operand_b;
		endcase
	end

	// Feeds the branch decision
	assign zero = (alu_result == '0);

endmodule

/* mips_control.sv */
`timescale 1ns/1ns

module mips_control (
	input  mips_pkg::opcode_t op,
	input  mips_pkg::funct_t  funct,
	input  logic              zero,
	input  logic              clk_enable,
	input  logic              halted,
	output logic              reg_write,
	output logic              reg_dst,
	output logic              alu_src,
	output logic              mem_to_reg,
	output logic              branch_taken,
	output logic              jump,
	output mips_pkg::alu_op_t alu_op,
	output logic              data_write,
	output logic              data_read
);
	import mips_pkg::*;

	logic dec_reg_write; // Raw decode, not yet qualified
	logic dec_mem_write;
	logic dec_mem_read;
	logic branch;        // beq seen
	logic funct_ok;      // Low for an unsupported R-type funct
	logic exec;          // Commit allowed this cycle

	// Main decoder
	always_comb begin : main_decode
		dec_reg_write = 1'b0; // Defaults give a no-op
		dec_mem_write = 1'b0;
		dec_mem_read  = 1'b0;
		reg_dst       = 1'b0;
		alu_src       = 1'b0;
		mem_to_reg    = 1'b0;
		branch        = 1'b0;
		jump          = 1'b0;
		case (op)
			OP_RTYPE: begin
				dec_reg_write = 1'b1;
				reg_dst       = 1'b1; // Write to rd
			end
			OP_LW: begin
				dec_reg_write = 1'b1;
				alu_src       = 1'b1; // Base plus offset
				mem_to_reg    = 1'b1;
				dec_mem_read  = 1'b1;
			end
			OP_SW: begin
				alu_src       = 1'b1;
				dec_mem_write = 1'b1;
			end
			OP_BEQ:  branch = 1'b1; // Compare by subtract
			OP_ADDI: begin
				dec_reg_write = 1'b1;
				alu_src       = 1'b1;
			end
			OP_J:    jump = 1'b1;
			default: ; // Unknown opcode, everything stays off
		endcase
	end

	// ALU decoder
	always_comb begin : alu_decode
		alu_op   = ALU_ADD; // lw, sw, addi and unknowns
		funct_ok = 1'b1;
		case (op)
			OP_BEQ: alu_op = ALU_SUB;
			OP_RTYPE: begin
				case (funct)
					FN_ADD:  alu_op = ALU_ADD;
					FN_SUB:  alu_op = ALU_SUB;
					FN_AND:  alu_op = ALU_AND;
					FN_OR:   alu_op = ALU_OR;
					FN_SLT:  alu_op = ALU_SLT;
					default: funct_ok = 1'b0; // Treated as a no-op
				endcase
			end
			default: ;
		endcase
	end

	// Nothing commits while stalled or after halt
	assign exec = clk_enable & ~halted;

	assign reg_write    = dec_reg_write & funct_ok & exec;
	assign data_write   = dec_mem_write & exec;
	assign data_read    = dec_mem_read & exec;
	assign branch_taken = branch & zero; // rs equals rt

endmodule

/* mips_cpu.sv */
`timescale 1ns/1ns
`include "mips_defines.svh"

module mips_cpu (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  clk_enable,
	output logic                  active,
	output logic [`MIPS_XLEN-1:0] register_v0,
	output logic [`MIPS_XLEN-1:0] instr_address,
	input  logic [`MIPS_XLEN-1:0] instr_readdata,
	output logic [`MIPS_XLEN-1:0] data_address,
	output logic                  data_write,
	output logic                  data_read,
	output logic [`MIPS_XLEN-1:0] data_writedata,
	input  logic [`MIPS_XLEN-1:0] data_readdata
);
	import mips_pkg::*;

	// Instruction fields
	opcode_t     op;
	funct_t      funct;
	logic [4:0]  rs;
	logic [4:0]  rt;
	logic [4:0]  rd;
	logic [15:0] imm16;
	logic [25:0] jump_index;

	// Control to datapath
	alu_op_t alu_op;
	logic    reg_write;
	logic    reg_dst;
	logic    alu_src;
	logic    mem_to_reg;
	logic    branch_taken;
	logic    jump;
	logic    zero;   // ALU result is zero
	logic    halted; // Core stopped

	logic [`MIPS_XLEN-1:0] rs_value;

	assign op         = opcode_t'(instr_readdata[31:26]);
	assign rs         = instr_readdata[25:21];
	assign rt         = instr_readdata[20:16];
	assign rd         = instr_readdata[15:11];
	assign imm16      = instr_readdata[15:0];
	assign funct      = funct_t'(instr_readdata[5:0]); // R-type only
	assign jump_index = instr_readdata[25:0];

	assign active = ~halted;

	mips_control ctrl0 (
		.op           (op),
		.funct        (funct),
		.zero         (zero),
		.clk_enable   (clk_enable),
		.halted       (halted),
		.reg_write    (reg_write),
		.reg_dst      (reg_dst),
		.alu_src      (alu_src),
		.mem_to_reg   (mem_to_reg),
		.branch_taken (branch_taken),
		.jump         (jump),
		.alu_op       (alu_op),
		.data_write   (data_write),
		.data_read    (data_read)
	);

	mips_pc_unit pcu0 (
		.clk          (clk),
		.reset        (reset),
		.clk_enable   (clk_enable),
		.branch_taken (branch_taken),
		.jump         (jump),
		.imm16        (imm16),
		.jump_index   (jump_index),
		.pc           (instr_address), // Fetch address
		.halted       (halted)
	);

	mips_regfile rf0 (
		.clk          (clk),
		.reg_write    (reg_write),
		.reg_dst      (reg_dst),
		.mem_to_reg   (mem_to_reg),
		.rs           (rs),
		.rt           (rt),
		.rd           (rd),
		.alu_result   (data_address),
		.mem_readdata (data_readdata),
		.rs_value     (rs_value),
		.rt_value     (data_writedata), // Store data for sw
		.v0           (register_v0)
	);

	mips_alu alu0 (
		.alu_op     (alu_op),
		.alu_src    (alu_src),
		.rs_value   (rs_value),
		.rt_value   (data_writedata),
		.imm16      (imm16),
		.alu_result (data_address), // Effective address for lw and sw
		.zero       (zero)
	);

endmodule

/* mips_defines.svh */
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

// Word width, used for data and addresses alike
`define MIPS_XLEN 32

// Architectural register count
`define MIPS_NREGS 32

// First fetch after reset, start of kseg1 boot ROM
`define MIPS_RESET_VECTOR 32'hBFC0_0000

// Jumping here ends the program
`define MIPS_HALT_ADDR 32'h0000_0000

// Register shown on register_v0 ($v0 by convention)
`define MIPS_V0 2

`endif

/* mips_pc_unit.sv */
`timescale 1ns/1ns
`include "mips_defines.svh"

module mips_pc_unit (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  clk_enable,
	input  logic                  branch_taken,
	input  logic                  jump,
	input  logic [15:0]           imm16,
	input  logic [25:0]           jump_index,
	output logic [`MIPS_XLEN-1:0] pc,
	output logic                  halted
);

	logic [`MIPS_XLEN-1:0] pc_plus4;
	logic [`MIPS_XLEN-1:0] branch_offset; // Sign-extended, word aligned
	logic [`MIPS_XLEN-1:0] branch_target;
	logic [`MIPS_XLEN-1:0] jump_target;
	logic [`MIPS_XLEN-1:0] pc_next;
	logic                  halt_jump;     // j with an all-zero index

	assign pc_plus4      = pc + 'd4;
	assign branch_offset = {{(`MIPS_XLEN-18){imm16[15]}}, imm16, 2'b00};
	assign branch_target = pc_plus4 + branch_offset;

	// The boot vector region bits can never form address zero,
	// so index zero is decoded as the halt call
	assign halt_jump   = (jump_index == '0);
	assign jump_target = halt_jump ? `MIPS_HALT_ADDR :
		{pc_plus4[`MIPS_XLEN-1:`MIPS_XLEN-4], jump_index, 2'b00};

	// Jump wins over branch, neither can be set together anyway
	always_comb begin
		if (jump)
			pc_next = jump_target;
		else if (branch_taken)
			pc_next = branch_target;
		else
			pc_next = pc_plus4;
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pc     <= `MIPS_RESET_VECTOR;
			halted <= 1'b0;
		end else if (clk_enable && !halted) begin // Hold on stall or halt
			pc <= pc_next;
			if (jump && jump_target == `MIPS_HALT_ADDR)
				halted <= 1'b1; // Sticky until reset
		end
	end

endmodule

/* mips_pkg.sv */
package mips_pkg;

	// Primary opcode, instr[31:26]
	typedef enum logic [5:0] {
		OP_RTYPE = 6'h00, // Uses funct field
		OP_J     = 6'h02,
		OP_BEQ   = 6'h04,
		OP_ADDI  = 6'h08,
		OP_LW    = 6'h23,
		OP_SW    = 6'h2B
	} opcode_t;

	// R-type function code, instr[5:0]
	typedef enum logic [5:0] {
		FN_ADD = 6'h20,
		FN_SUB = 6'h22,
		FN_AND = 6'h24,
		FN_OR  = 6'h25,
		FN_SLT = 6'h2A
	} funct_t;

	// ALU operation select
	// Bit 2 set means operand B is negated inside the adder path
	typedef enum logic [2:0] {
		ALU_AND = 3'b000,
		ALU_OR  = 3'b001,
		ALU_ADD = 3'b010,
		ALU_SUB = 3'b110,
		ALU_SLT = 3'b111 // Signed compare
	} alu_op_t;

endpackage

/* mips_regfile.sv */
`timescale 1ns/1ns
`include "mips_defines.svh"

module mips_regfile (
	input  logic                  clk,
	input  logic                  reg_write,
	input  logic                  reg_dst,
	input  logic                  mem_to_reg,
	input  logic [4:0]            rs,
	input  logic [4:0]            rt,
	input  logic [4:0]            rd,
	input  logic [`MIPS_XLEN-1:0] alu_result,
	input  logic [`MIPS_XLEN-1:0] mem_readdata,
	output logic [`MIPS_XLEN-1:0] rs_value,
	output logic [`MIPS_XLEN-1:0] rt_value,
	output logic [`MIPS_XLEN-1:0] v0
);

	logic [`MIPS_XLEN-1:0] regs [`MIPS_NREGS];
	logic [4:0]            dest;     // Write address
	logic [`MIPS_XLEN-1:0] wb_value; // Write data

	// rd for R-type, rt for lw and addi
	assign dest = reg_dst ? rd : rt;

	// Load data or ALU result
	assign wb_value = mem_to_reg ? mem_readdata : alu_result;

	// Single write port on the rising edge
	always_ff @(posedge clk) begin
		if (reg_write && dest != '0) // $zero never written
			regs[dest] <= wb_value;
	end

	// Two asynchronous read ports
	assign rs_value = (rs == '0) ? '0 : regs[rs];
	assign rt_value = (rt == '0) ? '0 : regs[rt];

	// Debug tap for the testbench
	assign v0 = regs[`MIPS_V0];

endmodule

/* tb_mips_cpu.sv */
`timescale 1ns/1ns
`include "mips_defines.svh"

module tb_mips_cpu;
	import mips_pkg::*;

	localparam int CYCLES_PER_INSTR = 40;
	localparam int STALL_FACTOR     = 2; // Room for random clk_enable gaps

	logic                  clk;
	logic                  reset;
	logic                  clk_enable;
	logic                  active;
	logic [`MIPS_XLEN-1:0] register_v0;
	logic [`MIPS_XLEN-1:0] instr_address;
	logic [`MIPS_XLEN-1:0] instr_readdata;
	logic [`MIPS_XLEN-1:0] data_address;
	logic                  data_write;
	logic                  data_read;
	logic [`MIPS_XLEN-1:0] data_writedata;
	logic [`MIPS_XLEN-1:0] data_readdata;

	integer                seed = 51525;
	int                    n_instr;         // Words in the current program
	int                    budget;          // Watchdog cycles left
	logic                  running;
	string                 prog_name;
	logic [`MIPS_XLEN-1:0] expected_v0;
	logic [`MIPS_XLEN-1:0] store_addr_q[$]; // Stores still due, in program order
	logic [`MIPS_XLEN-1:0] store_data_q[$];
	logic [`MIPS_XLEN-1:0] load_addr_q[$];  // Loads still due
	logic [`MIPS_XLEN-1:0] branch_pc;       // Taken beq, all ones if none
	logic [`MIPS_XLEN-1:0] branch_target;
	logic [`MIPS_XLEN-1:0] prev_pc;         // Sampled one negedge earlier
	logic                  prev_stall;
	logic                  prev_exec;
	logic                  prev_valid;

	mips_cpu dut0 (
		.clk            (clk),
		.reset          (reset),
		.clk_enable     (clk_enable),
		.active         (active),
		.register_v0    (register_v0),
		.instr_address  (instr_address),
		.instr_readdata (instr_readdata),
		.data_address   (data_address),
		.data_write     (data_write),
		.data_read      (data_read),
		.data_writedata (data_writedata),
		.data_readdata  (data_readdata)
	);

	tb_mips_mem mem0 (
		.clk            (clk),
		.instr_address  (instr_address),
		.instr_readdata (instr_readdata),
		.data_address   (data_address),
		.data_write     (data_write),
		.data_writedata (data_writedata),
		.data_readdata  (data_readdata)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk; // 20 ns period
	end

	task automatic fail_run(input string line);
		$display("Test failed");
		$display("%s", line);
		$fatal(1, "Simulation stopped at first error");
	endtask

	function automatic logic [`MIPS_XLEN-1:0] sext16(input logic [15:0] imm);
		return {{(`MIPS_XLEN-16){imm[15]}}, imm};
	endfunction

	function automatic logic [31:0] rtype_word(input funct_t fn, input int rd, input int rs,
		input int rt);
		return {OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
	endfunction

	function automatic logic [31:0] itype_word(input opcode_t op, input int rt, input int rs,
		input logic [15:0] imm);
		return {op, 5'(rs), 5'(rt), imm};
	endfunction

	task automatic append_instr(input logic [31:0] word);
		mem0.rom[8'(n_instr)] = word;
		n_instr++;
	endtask

	task automatic clear_program();
		for (int i = 0; i < 256; i++)
			mem0.rom[8'(i)] = '0; // Zero word, R-type with a dead funct
		n_instr = 0;
		store_addr_q.delete();
		store_data_q.delete();
		load_addr_q.delete();
		branch_pc     = '1;
		branch_target = '0;
	endtask

	task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
		store_addr_q.push_back(addr);
		store_data_q.push_back(data);
	endtask

	task automatic expect_load(input logic [31:0] addr);
		load_addr_q.push_back(addr);
	endtask

	task automatic check_reset_state(input string when);
		assert (instr_address == `MIPS_RESET_VECTOR && active && !data_write)
			else fail_run($sformatf("Mismatch at %0t: %s instr_address=%h active=%b data_write=%b",
				$time, when, instr_address, active, data_write));
	endtask

	task automatic check_store();
		logic [31:0] want_addr;
		logic [31:0] want_data;
		if (store_addr_q.size() == 0) begin
			fail_run($sformatf("Unexpected store to address %h at %0t", data_address, $time));
		end else begin
			want_addr = store_addr_q.pop_front();
			want_data = store_data_q.pop_front();
			assert (data_address == want_addr && data_writedata == want_data)
				else fail_run($sformatf({"Mismatch at %0t: data_address=%h data_writedata=%h,",
					" expected %h and %h"}, $time, data_address, data_writedata,
					want_addr, want_data));
		end
	endtask

	task automatic check_load();
		logic [31:0] want_addr;
		if (load_addr_q.size() == 0) begin
			fail_run($sformatf("Unexpected load from address %h at %0t", data_address, $time));
		end else begin
			want_addr = load_addr_q.pop_front();
			assert (data_address == want_addr)
				else fail_run($sformatf("Mismatch at %0t: data_address=%h on load, expected %h",
					$time, data_address, want_addr));
		end
	endtask

	// Watchdog, budget scales with program length
	always @(posedge clk) begin : watchdog
		if (running) begin
			if (budget <= 0)
				fail_run($sformatf("Watchdog expired, program %s never halted", prog_name));
			else
				budget = budget - 1;
		end
	end

	// All per-cycle checks, sampled mid-cycle where signals are settled
	always @(negedge clk) begin : monitor
		if (reset) begin
			check_reset_state("during reset");
			prev_valid = 1'b0;
		end else begin
			if (prev_valid && prev_stall) // Stalled edge must not move the PC
				assert (instr_address == prev_pc)
					else fail_run($sformatf("Mismatch at %0t: instr_address=%h moved from %h on stall",
						$time, instr_address, prev_pc));
			if (prev_valid && prev_exec && prev_pc == branch_pc)
				assert (instr_address == branch_target)
					else fail_run($sformatf("Mismatch at %0t: instr_address=%h after beq, expected %h",
						$time, instr_address, branch_target));
			if (!clk_enable)
				assert (!data_write && !data_read)
					else fail_run($sformatf("Mismatch at %0t: data_write=%b data_read=%b while stalled",
						$time, data_write, data_read));
			if (!active)
				assert (instr_address == `MIPS_HALT_ADDR && !data_write)
					else fail_run($sformatf("Mismatch at %0t: instr_address=%h data_write=%b after halt",
						$time, instr_address, data_write));
			if (data_write)
				check_store();
			if (data_read)
				check_load();
			prev_valid = 1'b1;
			prev_pc    = instr_address;
			prev_stall = !clk_enable;
			prev_exec  = clk_enable && active;
		end
	end

	task automatic run_program(input string name);
		prog_name = name;
		@(posedge clk);
		reset      <= 1'b1;
		clk_enable <= 1'b0;
		repeat (16) @(posedge clk);
		reset <= 1'b0; // clk_enable stays low one more cycle
		@(negedge clk);
		check_reset_state("just after reset");
		budget  = n_instr * CYCLES_PER_INSTR * STALL_FACTOR;
		running = 1'b1;
		while (active) begin
			@(posedge clk);
			// Every fetched instruction sits through at least one stall
			clk_enable <= clk_enable ? 1'b0 : (($random(seed) % 4) != 0);
			@(negedge clk);
		end
		running = 1'b0;
		repeat (20) begin // Halt must stick
			@(posedge clk);
			clk_enable <= ($random(seed) % 4) != 0;
		end
		@(negedge clk);
		assert (!active && register_v0 == expected_v0)
			else fail_run($sformatf("Mismatch at %0t: %s active=%b register_v0=%h expected_v0=%h",
				$time, name, active, register_v0, expected_v0));
		assert (store_addr_q.size() == 0 && load_addr_q.size() == 0)
			else fail_run($sformatf("Program %s ended with %0d stores and %0d loads never seen",
				name, store_addr_q.size(), load_addr_q.size()));
	endtask

	task automatic build_arith();
		logic [15:0] a_imm;
		logic [15:0] b_imm;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] lt_ab;
		logic [31:0] lt_ba;
		a_imm = 16'($random(seed));
		b_imm = 16'($random(seed)) | 16'h8000; // Always negative
		a     = sext16(a_imm);
		b     = sext16(b_imm);
		lt_ab = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
		lt_ba = ($signed(b) < $signed(a)) ? 32'd1 : 32'd0;
		clear_program();
		append_instr(itype_word(OP_ADDI, 8, 0, a_imm));
		append_instr(itype_word(OP_ADDI, 9, 0, b_imm));
		append_instr(rtype_word(FN_ADD, 10, 8, 9));
		append_instr(rtype_word(FN_SUB, 11, 8, 9));
		append_instr(rtype_word(FN_AND, 12, 10, 11));
		append_instr(rtype_word(FN_OR, 13, 12, 8));
		append_instr(rtype_word(FN_SLT, 14, 8, 9));
		append_instr(rtype_word(FN_SLT, 15, 9, 8));
		append_instr(rtype_word(FN_ADD, 2, 13, 14));
		append_instr(rtype_word(FN_SUB, 2, 2, 15));
		append_instr({6'h3F, 5'd0, 5'd2, 16'hFFFF}); // Unknown opcode aimed at v0
		append_instr({OP_J, 26'd0});                 // Jump to zero ends the run
		expected_v0 = (((a + b) & (a - b)) | a) + lt_ab - lt_ba;
	endtask

	task automatic build_memory();
		logic [31:0] base;
		logic [15:0] val_imm;
		base    = 32'h100 + (32'($random(seed)) & 32'h1F0);
		val_imm = 16'($random(seed));
		clear_program();
		append_instr(itype_word(OP_ADDI, 8, 0, base[15:0]));
		append_instr(itype_word(OP_ADDI, 9, 0, val_imm));
		append_instr(itype_word(OP_SW, 9, 8, 16'd4));
		expect_store(base + 32'd4, sext16(val_imm));
		append_instr(itype_word(OP_SW, 8, 8, 16'hFFF8)); // Negative offset
		expect_store(base - 32'd8, base);
		append_instr(itype_word(OP_LW, 10, 8, 16'd4));
		expect_load(base + 32'd4);
		append_instr(rtype_word(FN_ADD, 2, 10, 0)); // Move into v0
		append_instr({OP_J, 26'd0});
		expected_v0 = sext16(val_imm);
	endtask

	task automatic build_branch();
		clear_program();
		append_instr(itype_word(OP_ADDI, 8, 0, 16'd5));
		append_instr(itype_word(OP_ADDI, 9, 0, 16'd5));
		append_instr(itype_word(OP_ADDI, 10, 0, 16'd7));
		append_instr(itype_word(OP_ADDI, 2, 0, 16'd1));
		branch_pc     = `MIPS_RESET_VECTOR + 32'(n_instr * 4);
		branch_target = branch_pc + 32'd4 + (sext16(16'd1) << 2);
		append_instr(itype_word(OP_BEQ, 9, 8, 16'd1));    // Equal, skips next
		append_instr(itype_word(OP_ADDI, 2, 2, 16'd16));
		append_instr(itype_word(OP_BEQ, 10, 8, 16'd1));   // Not equal, falls through
		append_instr(itype_word(OP_ADDI, 2, 2, 16'd256));
		append_instr({OP_J, 26'd0});
		expected_v0 = 32'd1 + 32'd256;
	endtask

	initial begin : main
		reset      = 1'b1;
		clk_enable = 1'b0;
		running    = 1'b0;
		prev_valid = 1'b0;
		prev_pc    = '0;
		prev_stall = 1'b0;
		prev_exec  = 1'b0;
		build_arith();
		run_program("arithmetic");
		build_memory();
		run_program("memory");
		build_branch();
		run_program("branch");
		$display("Test passed");
		$finish;
	end

endmodule

/* tb_mips_mem.sv */
`timescale 1ns/1ns
`include "mips_defines.svh"

module tb_mips_mem (
	input  logic                  clk,
	input  logic [`MIPS_XLEN-1:0] instr_address,
	output logic [`MIPS_XLEN-1:0] instr_readdata,
	input  logic [`MIPS_XLEN-1:0] data_address,
	input  logic                  data_write,
	input  logic [`MIPS_XLEN-1:0] data_writedata,
	output logic [`MIPS_XLEN-1:0] data_readdata
);

	localparam int ROM_WORDS = 256;
	localparam int RAM_WORDS = 256;

	logic [`MIPS_XLEN-1:0] rom [ROM_WORDS]; // Filled by the testbench top
	logic [`MIPS_XLEN-1:0] ram [RAM_WORDS];
	logic [`MIPS_XLEN-1:0] rom_offset;      // Byte offset from the boot vector

	// Each word carries its own byte address in the low bits
	initial begin
		for (int i = 0; i < RAM_WORDS; i++)
			ram[8'(i)] <= 32'hC0DE_0000 | 32'(i << 2);
	end

	assign rom_offset = instr_address - `MIPS_RESET_VECTOR;

	// Outside the ROM window reads as a no-op word
	assign instr_readdata = (rom_offset < 32'(ROM_WORDS * 4)) ? rom[rom_offset[9:2]] : '0;

	// Word index only, upper address bits alias
	assign data_readdata = ram[data_address[9:2]];

	always @(posedge clk) begin
		if (data_write)
			ram[data_address[9:2]] <= data_writedata; // Already gated by clk_enable
	end

endmodule
